//--- dds_vectors.txt
// wave record: 1 wave_sel mod_sel phase_inc cycles (wave 0 sin 1 cos 2 saw 3 square)
// key record:  2 ready event_code expected_held_keys 0 (mod 0 ask 1 bpsk 2 prbs 3 plain)
1 0 3 01000000 00000104   // plain sine, one period plus latency
1 1 3 01000000 00000104
1 2 3 01000000 00000104
1 3 3 01000000 00000104
1 2 0 00800000 00000440   // ask keys the sine whatever the carrier
1 2 1 00400000 000002c0   // bpsk on saw
1 3 1 02000000 00000190   // bpsk on square
1 1 1 01234567 0000012c   // bpsk on cosine, odd step
1 0 2 01000000 00000800   // bit display over 64 symbols
2 1 16 00010000 0         // key 1 make
2 1 16 00010000 0         // repeated make
2 1 72 00010001 0
2 1 29 00010011 0
2 0 1e 00010011 0         // code with ready low
2 1 00 00010011 0         // unknown codes
2 1 ff 00010011 0
2 1 96 00000011 0         // key 1 break
2 1 05 00000111 0
2 1 06 00000191 0
2 1 6b 00000199 0
2 1 f2 00000198 0
2 1 a9 00000188 0
2 1 31 000001c8 0
2 1 3a 000001e8 0
2 1 74 000001ec 0
2 1 75 000001ee 0
2 1 3e 000003ee 0
2 1 1e 000083ee 0
2 0 85 000083ee 0
2 1 85 000082ee 0
2 1 80 000082ee 0         // flag alone
2 1 26 0000c2ee 0
2 1 bd 0000c2ee 0         // break of a key not held
0 0 0 0 0

//--- build.f
+incdir+.
dds_pkg.sv
dds_waveform_gen.sv
prbs_source.sv
keying_modulator.sv
held_key_tracker.sv
dds_modem_top.sv
dds_modem_props.sv
tb_dds_modem.sv

//--- Makefile
VERILATOR   = verilator
TOP         = tb_dds_modem
FILELIST    = build.f
OBJ_DIR     = obj_dir
BUILD_FLAGS = --binary --timing --assert -Wno-fatal
LINT_FLAGS  = --lint-only --timing --assert -Wall
RUN_FLAGS   = +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- tb_dds_modem.sv
`timescale 1ns/10ps
`include "dds_config.svh"

module tb_dds_modem;
   import dds_pkg::*;

   localparam int         max_words  = 512;
   localparam int         rec_words  = 5;
   localparam int         table_size = 1 << `DDS_TABLE_BITS;
   localparam logic [4:0] lfsr_seed  = `DDS_LFSR_SEED;

   logic       CLK_25MHZ;
   logic       reset_from_key;
   phase_t     phase_inc;
   wave_sel_e  wave_sel;
   mod_sel_e   mod_sel;
   logic       event_ready;
   key_code_t  event_code;
   sample_t    mod_out;
   logic       prbs_bit;
   held_keys_t held_keys;

   logic [31:0] vec_mem [0:max_words-1];
   sample_t     sine_ref [0:table_size-1];

   dds_modem_top i_dds_modem_top
   (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .phase_inc      (phase_inc),
      .wave_sel       (wave_sel),
      .mod_sel        (mod_sel),
      .event_ready    (event_ready),
      .event_code     (event_code),
      .mod_out        (mod_out),
      .prbs_bit       (prbs_bit),
      .held_keys      (held_keys)
   );

   initial
   begin
      CLK_25MHZ = 1'b0;
      forever #20 CLK_25MHZ = ~CLK_25MHZ;   // 40 ns period
   end

   ////////////////////////////////////////////////////////////
   // reference model
   ////////////////////////////////////////////////////////////
   task automatic build_sine_table();
      real angle;
      real scaled;
      for (int i = 0; i < table_size; i++)
      begin
         angle       = 2.0 * 3.141592653589793 * real'(i) / real'(table_size);
         scaled      = 2047.0 * $sin(angle);
         sine_ref[i] = sample_t'($rtoi($floor(scaled + 0.5)));
      end
   endtask

   // lfsr bit 0 in cycle k after reset release
   function automatic logic expected_prbs(input int k);
      logic [4:0] state;
      state = lfsr_seed;
      for (int n = 0; n < k / `DDS_SYMBOL_DIV; n++)
         state = {state[3:0], state[4] ^ state[2]};
      return state[0];
   endfunction

   function automatic sample_t wave_value(input phase_t p, input wave_sel_e wsel);
      int idx;
      idx = int'(p >> (`DDS_PHASE_W - `DDS_TABLE_BITS));
      case (wsel)
         wave_sine:   return sine_ref[idx];
         wave_cosine: return sine_ref[(idx + table_size / 4) % table_size];
         wave_saw:    return sample_t'(p >> (`DDS_PHASE_W - `DDS_SAMPLE_W));
         default:     return p[`DDS_PHASE_W-1] ? sample_t'(-2047) : sample_t'(2047);
      endcase
   endfunction

   // mod_out in cycle k comes from the wave registers and prbs of k-1,
   // the wave registers of k-1 carry the phase of k-2
   function automatic sample_t expected_mod(input int k, input phase_t inc,
                                            input wave_sel_e wsel, input mod_sel_e msel);
      phase_t  p;
      sample_t carrier;
      sample_t sine_now;
      logic    bit_now;
      if (k < 1)
         return '0;
      bit_now = expected_prbs(k - 1);
      if (k < 2)
      begin
         carrier  = '0;   // wave registers still at reset in cycle 0
         sine_now = '0;
      end
      else
      begin
         p        = phase_t'(k - 2) * inc;
         carrier  = wave_value(p, wsel);
         sine_now = wave_value(p, wave_sine);
      end
      case (msel)
         mod_ask:  return bit_now ? sine_now : sample_t'(0);
         mod_bpsk: return bit_now ? sample_t'(-int'(carrier)) : carrier;
         mod_prbs: return bit_now ? sample_t'(12'h800) : sample_t'(0);
         default:  return carrier;
      endcase
   endfunction

   ////////////////////////////////////////////////////////////
   // checking
   ////////////////////////////////////////////////////////////
   task automatic stop_on_error();
      $display("TEST FAIL");
      $fatal(1, "first error, simulation stopped");
   endtask

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      assert (act === exp)
      else
      begin
         $display("MISMATCH %s expected %h actual %h", name, exp, act);
         stop_on_error();
      end
   endtask

   // bound property checkers count their failures
   always @(negedge CLK_25MHZ)
   begin
      assert (i_dds_modem_top.i_prbs_source.i_prbs_props.fail_count == 0
              && i_dds_modem_top.i_held_key_tracker.i_key_props.fail_count == 0)
      else
      begin
         $display("a concurrent assertion in dds_modem_props failed");
         stop_on_error();
      end
   end

   // first lfsr shift lands one symbol after release, seed bit 1 -> 0
   task automatic check_first_shift();
      int waited;
      waited = 0;
      while (prbs_bit === 1'b1 && waited < 4 * `DDS_SYMBOL_DIV)
      begin
         @(negedge CLK_25MHZ);
         waited++;
      end
      if (prbs_bit === 1'b1)
      begin
         $display("timeout: prbs_bit never left its seed value");
         stop_on_error();
      end
      check_value("first symbol length", `DDS_SYMBOL_DIV, waited);
   endtask

   task automatic run_wave_record(input int rec, input wave_sel_e wsel,
                                  input mod_sel_e msel, input phase_t inc, input int cycles);
      logic  sym_bits [$];
      string tag;
      @(posedge CLK_25MHZ);
      reset_from_key <= 1'b1;   // new mode under reset
      wave_sel       <= wsel;
      mod_sel        <= msel;
      phase_inc      <= inc;
      repeat (2) @(posedge CLK_25MHZ);
      reset_from_key <= 1'b0;
      for (int k = 0; k < cycles; k++)
      begin
         @(negedge CLK_25MHZ);
         tag = $sformatf("record %0d cycle %0d", rec, k);
         check_value({tag, " mod_out"}, expected_mod(k, inc, wsel, msel), mod_out);
         check_value({tag, " prbs_bit"}, expected_prbs(k), prbs_bit);
         if (k % `DDS_SYMBOL_DIV == `DDS_SYMBOL_DIV / 2)
            sym_bits.push_back(prbs_bit);   // mid symbol
      end
      // symbol s+31 repeats the model bit of symbol s
      for (int s = 0; s + 31 < sym_bits.size(); s++)
         check_value($sformatf("record %0d prbs period symbol %0d", rec, s),
                     expected_prbs(s * `DDS_SYMBOL_DIV + `DDS_SYMBOL_DIV / 2),
                     sym_bits[s+31]);
   endtask

   task automatic run_key_record(input int rec, input logic ready, input key_code_t code,
                                 input held_keys_t expected);
      @(posedge CLK_25MHZ);
      event_ready <= ready;
      event_code  <= code;
      @(posedge CLK_25MHZ);
      event_ready <= 1'b0;
      event_code  <= 8'h00;
      @(negedge CLK_25MHZ);
      check_value($sformatf("key record %0d held_keys", rec), expected, held_keys);
   endtask

   ////////////////////////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////////////////////////
   initial
   begin
      int ptr;
      int rec;
      int prop_fails;
      reset_from_key = 1'b1;
      phase_inc      = '0;
      wave_sel       = wave_sine;
      mod_sel        = mod_plain;
      event_ready    = 1'b0;
      event_code     = '0;
      build_sine_table();
      $readmemh("dds_vectors.txt", vec_mem);

      repeat (8) @(posedge CLK_25MHZ);
      reset_from_key <= 1'b0;
      @(negedge CLK_25MHZ);
      check_value("reset mod_out", 0, mod_out);
      check_value("reset held_keys", 0, held_keys);
      check_value("reset prbs_bit", lfsr_seed[0], prbs_bit);
      check_first_shift();

      ptr = 0;
      rec = 0;
      while (ptr + rec_words <= max_words && vec_mem[ptr] !== 32'd0)
      begin
         case (vec_mem[ptr])
            32'd1: run_wave_record(rec, wave_sel_e'(vec_mem[ptr+1][1:0]),
                                   mod_sel_e'(vec_mem[ptr+2][1:0]),
                                   vec_mem[ptr+3], int'(vec_mem[ptr+4]));
            32'd2: run_key_record(rec, vec_mem[ptr+1][0], vec_mem[ptr+2][7:0],
                                  vec_mem[ptr+3][`DDS_KEY_COUNT-1:0]);
            default:
            begin
               $display("vector file has an unknown record kind at word %0d", ptr);
               stop_on_error();
            end
         endcase
         ptr += rec_words;
         rec++;
      end
      if (rec == 0)
      begin
         $display("vector file holds no records");
         stop_on_error();
      end

      prop_fails = i_dds_modem_top.i_prbs_source.i_prbs_props.fail_count
                 + i_dds_modem_top.i_held_key_tracker.i_key_props.fail_count;
      if (prop_fails == 0)
      begin
         $display("TEST PASS");
         $finish;
      end
      else
      begin
         $display("%0d concurrent assertion failures", prop_fails);
         $display("TEST FAIL");
         $fatal(1, "concurrent assertions failed");
      end
   end

endmodule

//--- dds_modem_props.sv
`timescale 1ns/10ps
`include "dds_config.svh"

module dds_modem_props
#(
   parameter int               width       = 1,
   parameter logic [width-1:0] reset_value = '0
)
(
   input logic             CLK_25MHZ,
   input logic             reset_from_key,
   input logic             update_en,       // strobe that may change watched
   input logic [width-1:0] watched
);

   int fail_count = 0;

   // no change unless the strobe was high the cycle before
   hold_between_updates: assert property (@(posedge CLK_25MHZ)
      (!reset_from_key && !$past(reset_from_key) && !$past(update_en)) |-> $stable(watched))
   else
   begin
      fail_count++;
      $error("output changed without an update strobe in the previous cycle");
   end

   reset_state: assert property (@(posedge CLK_25MHZ)
      $past(reset_from_key) |-> (watched == reset_value))
   else
   begin
      fail_count++;
      $error("output not at its reset value in the cycle after reset");
   end

endmodule

////////////////////////////////////////////////////////////
// attach to the lfsr and the key register
////////////////////////////////////////////////////////////
bind prbs_source dds_modem_props #(.width(1), .reset_value(1'(`DDS_LFSR_SEED))) i_prbs_props
(
   .CLK_25MHZ      (CLK_25MHZ),
   .reset_from_key (reset_from_key),
   .update_en      (symbol_tick),   // counter wrap
   .watched        (prbs_bit)
);

bind held_key_tracker dds_modem_props #(.width(`DDS_KEY_COUNT)) i_key_props
(
   .CLK_25MHZ      (CLK_25MHZ),
   .reset_from_key (reset_from_key),
   .update_en      (event_ready),
   .watched        (held_keys)
);

//--- dds_modem_top.sv
`timescale 1ns/10ps

module dds_modem_top
(
   input  logic                CLK_25MHZ,
   input  logic                reset_from_key,
   input  dds_pkg::phase_t     phase_inc,
   input  dds_pkg::wave_sel_e  wave_sel,
   input  dds_pkg::mod_sel_e   mod_sel,
   input  logic                event_ready,
   input  dds_pkg::key_code_t  event_code,
   output dds_pkg::sample_t    mod_out,
   output logic                prbs_bit,
   output dds_pkg::held_keys_t held_keys
);
   import dds_pkg::*;

   sample_t sine;
   sample_t cosine;
   sample_t saw;
   sample_t square;

   ////////////////////////////////////////////////////////////
   // signal path, nco -> keying
   ////////////////////////////////////////////////////////////
   dds_waveform_gen i_waveform_gen
   (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .phase_inc      (phase_inc),
      .sine           (sine),
      .cosine         (cosine),
      .saw            (saw),
      .square         (square)
   );

   prbs_source i_prbs_source
   (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .prbs_bit       (prbs_bit)
   );

   keying_modulator i_keying_modulator
   (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .sine           (sine),
      .cosine         (cosine),
      .saw            (saw),
      .square         (square),
      .prbs_bit       (prbs_bit),
      .wave_sel       (wave_sel),
      .mod_sel        (mod_sel),
      .mod_out        (mod_out)
   );

   // keyboard side, independent of the signal path
   held_key_tracker i_held_key_tracker
   (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .event_ready    (event_ready),
      .event_code     (event_code),
      .held_keys      (held_keys)
   );

endmodule

//--- held_key_tracker.sv
`timescale 1ns/10ps
`include "dds_config.svh"

module held_key_tracker
(
   input  logic                CLK_25MHZ,
   input  logic                reset_from_key,
   input  logic                event_ready,
   input  dds_pkg::key_code_t  event_code,
   output dds_pkg::held_keys_t held_keys
);
   import dds_pkg::*;

   ////////////////////////////////////////////////////////////
   // make code per bit, leftmost entry lands on the top bit
   ////////////////////////////////////////////////////////////
   localparam key_code_t make_codes [`DDS_KEY_COUNT-1:0] = '{
      `SC_MAKE_1,
      `SC_MAKE_2,
      `SC_MAKE_3,
      `SC_MAKE_4,
      `SC_MAKE_5,
      `SC_MAKE_6,
      `SC_MAKE_7,
      `SC_MAKE_8,
      `SC_MAKE_F1,
      `SC_MAKE_F2,
      `SC_MAKE_N,
      `SC_MAKE_M,
      `SC_MAKE_SPACE,
      `SC_MAKE_LEFT,
      `SC_MAKE_RIGHT,
      `SC_MAKE_UP,
      `SC_MAKE_DOWN
   };

   held_keys_t keys_next;

   // one code matches at most one bit, others keep their state
   always_comb
   begin
      keys_next = held_keys;
      for (int i = 0; i < `DDS_KEY_COUNT; i++)
      begin
         if (event_code == make_codes[i])
            keys_next[i] = 1'b1;
         else if (event_code == (make_codes[i] | `SC_BREAK_FLAG))
            keys_next[i] = 1'b0;   // break form
      end
   end

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         held_keys <= '0;
      else if (event_ready)       // code only valid with the strobe
         held_keys <= keys_next;
   end

endmodule

//--- keying_modulator.sv
`timescale 1ns/10ps
`include "dds_config.svh"

module keying_modulator
(
   input  logic               CLK_25MHZ,
   input  logic               reset_from_key,
   input  dds_pkg::sample_t   sine,
   input  dds_pkg::sample_t   cosine,
   input  dds_pkg::sample_t   saw,
   input  dds_pkg::sample_t   square,
   input  logic               prbs_bit,
   input  dds_pkg::wave_sel_e wave_sel,
   input  dds_pkg::mod_sel_e  mod_sel,
   output dds_pkg::sample_t   mod_out
);
   import dds_pkg::*;

   // only the sign bit set, for the bit display
   localparam sample_t bit_high = {1'b1, {(`DDS_SAMPLE_W-1){1'b0}}};

   sample_t sel_wave;
   sample_t ask;
   sample_t bpsk;
   sample_t bit_disp;
   sample_t mod_next;

   always_comb
   begin
      case (wave_sel)
         wave_sine:   sel_wave = sine;
         wave_cosine: sel_wave = cosine;
         wave_saw:    sel_wave = saw;
         default:     sel_wave = square;
      endcase
   end

   assign ask      = prbs_bit ? sine : '0;             // ask always keys the sine
   assign bpsk     = prbs_bit ? -sel_wave : sel_wave;  // phase flip on a one
   assign bit_disp = prbs_bit ? bit_high : '0;

   always_comb
   begin
      case (mod_sel)
         mod_ask:  mod_next = ask;
         mod_bpsk: mod_next = bpsk;
         mod_prbs: mod_next = bit_disp;
         default:  mod_next = sel_wave;   // plain carrier
      endcase
   end

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         mod_out <= '0;
      else
         mod_out <= mod_next;
   end

endmodule

//--- prbs_source.sv
`timescale 1ns/10ps
`include "dds_config.svh"

module prbs_source
(
   input  logic CLK_25MHZ,
   input  logic reset_from_key,
   output logic prbs_bit
);

   localparam int cnt_w = $clog2(`DDS_SYMBOL_DIV);

   typedef logic [cnt_w-1:0] count_t;

   localparam count_t cnt_last = count_t'(`DDS_SYMBOL_DIV - 1);

   count_t     symbol_count;
   logic       symbol_tick;
   logic [4:0] lfsr_state;

   // symbol rate enable, high in the wrap cycle
   assign symbol_tick = (symbol_count == cnt_last);

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         symbol_count <= '0;
      else if (symbol_tick)
         symbol_count <= '0;
      else
         symbol_count <= symbol_count + 1'b1;
   end

   // 5 bit fibonacci, taps 5 and 3, period 31
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         lfsr_state <= `DDS_LFSR_SEED;
      else if (symbol_tick)
         lfsr_state <= {lfsr_state[3:0], lfsr_state[4] ^ lfsr_state[2]};
   end

   assign prbs_bit = lfsr_state[0];

endmodule

//--- dds_waveform_gen.sv
`timescale 1ns/10ps
`include "dds_config.svh"

module dds_waveform_gen
(
   input  logic             CLK_25MHZ,
   input  logic             reset_from_key,
   input  dds_pkg::phase_t  phase_inc,
   output dds_pkg::sample_t sine,
   output dds_pkg::sample_t cosine,
   output dds_pkg::sample_t saw,
   output dds_pkg::sample_t square
);
   import dds_pkg::*;

   typedef logic [`DDS_TABLE_BITS-1:0] table_addr_t;

   localparam int          table_size   = 1 << `DDS_TABLE_BITS;
   localparam table_addr_t quarter_turn = table_addr_t'(table_size / 4);
   localparam sample_t     full_scale   = sample_t'((1 << (`DDS_SAMPLE_W - 1)) - 1);
   localparam real         two_pi       = 6.283185307179586;

   phase_t      phase_acc;
   table_addr_t sin_idx;
   table_addr_t cos_idx;
   sample_t     sine_table [0:table_size-1];

   // round(full_scale * sin(2 pi i / N)), half away from zero
   function automatic sample_t sine_entry(input int i);
      real scaled;
      scaled = real'(full_scale) * $sin(two_pi * real'(i) / real'(table_size));
      if (scaled >= 0.0)
         return sample_t'($rtoi(scaled + 0.5));
      else
         return sample_t'($rtoi(scaled - 0.5));
   endfunction

   initial
   begin
      for (int i = 0; i < table_size; i++)
         sine_table[i] = sine_entry(i);
   end

   ////////////////////////////////////////////////////////////
   // phase accumulator
   ////////////////////////////////////////////////////////////
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         phase_acc <= '0;
      else
         phase_acc <= phase_acc + phase_inc;
   end

   assign sin_idx = phase_acc[`DDS_PHASE_W-1 -: `DDS_TABLE_BITS];
   assign cos_idx = sin_idx + quarter_turn;   // 90 degrees ahead, wraps

   ////////////////////////////////////////////////////////////
   // wave registers, one cycle behind the accumulator
   ////////////////////////////////////////////////////////////
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         sine   <= '0;
         cosine <= '0;
         saw    <= '0;
         square <= '0;
      end
      else
      begin
         sine   <= sine_table[sin_idx];
         cosine <= sine_table[cos_idx];
         saw    <= $signed(phase_acc[`DDS_PHASE_W-1 -: `DDS_SAMPLE_W]);  // top bits as ramp
         square <= phase_acc[`DDS_PHASE_W-1] ? -full_scale : full_scale;
      end
   end

endmodule

//--- dds_pkg.sv
`include "dds_config.svh"

package dds_pkg;

   // accumulator and sample formats
   typedef logic [`DDS_PHASE_W-1:0] phase_t;
   typedef logic signed [`DDS_SAMPLE_W-1:0] sample_t;   // two's complement

   // carrier wave choice
   typedef enum logic [1:0]
   {
      wave_sine   = 2'd0,
      wave_cosine = 2'd1,
      wave_saw    = 2'd2,
      wave_square = 2'd3
   } wave_sel_e;

   // output shaping choice
   typedef enum logic [1:0]
   {
      mod_ask   = 2'd0,
      mod_bpsk  = 2'd1,
      mod_prbs  = 2'd2,
      mod_plain = 2'd3
   } mod_sel_e;

   typedef logic [7:0] key_code_t;

   // bit 16 is key 1 ... bit 0 is down arrow
   typedef logic [`DDS_KEY_COUNT-1:0] held_keys_t;

endpackage

//--- dds_config.svh
`ifndef DDS_CONFIG_SVH
`define DDS_CONFIG_SVH

////////////////////////////////////////////////////////////
// datapath widths
////////////////////////////////////////////////////////////
`define DDS_PHASE_W      32
`define DDS_SAMPLE_W     12
`define DDS_TABLE_BITS   8        // 256 entry sine table

// symbol rate and pseudo-random source
`define DDS_SYMBOL_DIV   32       // clock cycles per symbol
`define DDS_LFSR_SEED    5'b00001

`define DDS_KEY_COUNT    17

////////////////////////////////////////////////////////////
// keyboard make codes, break = make | flag
////////////////////////////////////////////////////////////
`define SC_BREAK_FLAG    8'h80

`define SC_MAKE_1        8'h16
`define SC_MAKE_2        8'h1E
`define SC_MAKE_3        8'h26
`define SC_MAKE_4        8'h25
`define SC_MAKE_5        8'h2E
`define SC_MAKE_6        8'h36
`define SC_MAKE_7        8'h3D
`define SC_MAKE_8        8'h3E
`define SC_MAKE_F1       8'h05
`define SC_MAKE_F2       8'h06
`define SC_MAKE_N        8'h31
`define SC_MAKE_M        8'h3A
`define SC_MAKE_SPACE    8'h29
`define SC_MAKE_LEFT     8'h6B    // arrows
`define SC_MAKE_RIGHT    8'h74
`define SC_MAKE_UP       8'h75
`define SC_MAKE_DOWN     8'h72

`endif
